// ==== common/zk_params.svh ====
/*
 * Scalar crypto unit parameters
 * Word width, AES field polynomial and bytes per word
 */
`ifndef ZK_PARAMS_SVH
`define ZK_PARAMS_SVH

// Data word width of the RV32 datapath
`define ZK_XLEN 32

// Reduction polynomial x^8 + x^4 + x^3 + x + 1, top bit implied
`define ZK_AES_POLY 8'h1b

// AES state bytes carried in one data word
`define ZK_BYTES 4

`endif

// ==== common/zk_op_pkg.sv ====
/*
 * Scalar crypto operation codes
 * AES32 codes sit at 16..31 as {1, decrypt, mix, byte index}
 */
`default_nettype none

package zk_op_pkg;

  typedef enum logic [4:0] {
    ZK_NONE         = 5'd0,
    ZK_SHA256SUM0   = 5'd1,
    ZK_SHA256SUM1   = 5'd2,
    ZK_SHA256SIG0   = 5'd3,
    ZK_SHA256SIG1   = 5'd4,
    ZK_SHA512SUM0R  = 5'd5,
    ZK_SHA512SUM1R  = 5'd6,
    ZK_SHA512SIG0L  = 5'd7,
    ZK_SHA512SIG0H  = 5'd8,
    ZK_SHA512SIG1L  = 5'd9,
    ZK_SHA512SIG1H  = 5'd10,
    ZK_AES32ESB0    = 5'd16,
    ZK_AES32ESB1    = 5'd17,
    ZK_AES32ESB2    = 5'd18,
    ZK_AES32ESB3    = 5'd19,
    ZK_AES32ESMB0   = 5'd20,
    ZK_AES32ESMB1   = 5'd21,
    ZK_AES32ESMB2   = 5'd22,
    ZK_AES32ESMB3   = 5'd23,
    ZK_AES32DSB0    = 5'd24,
    ZK_AES32DSB1    = 5'd25,
    ZK_AES32DSB2    = 5'd26,
    ZK_AES32DSB3    = 5'd27,
    ZK_AES32DSMB0   = 5'd28,
    ZK_AES32DSMB1   = 5'd29,
    ZK_AES32DSMB2   = 5'd30,
    ZK_AES32DSMB3   = 5'd31
  } zk_op_e;

  function automatic logic zk_op_is_aes32(zk_op_e op);
    return op[4];
  endfunction

  function automatic logic zk_op_is_sha(zk_op_e op);
    return (op >= ZK_SHA256SUM0) && (op <= ZK_SHA512SIG1H);
  endfunction

endpackage

`default_nettype wire

// ==== common/zk_data_pkg.sv ====
/*
 * Scalar crypto data types
 * Words, AES bytes, request and response, GF(2^8) helpers
 */
`default_nettype none

`include "zk_params.svh"

package zk_data_pkg;
  import zk_op_pkg::*;

  typedef logic [`ZK_XLEN-1:0] zk_word_t;
  typedef logic [7:0]          zk_byte_t;

  typedef struct packed {
    logic     valid;
    zk_op_e   op;
    zk_word_t operand_a;
    zk_word_t operand_b;
  } zk_req_t;

  typedef struct packed {
    logic     valid;
    logic     hit;
    zk_word_t result;
  } zk_rsp_t;

  // Multiply by x modulo the AES polynomial
  function automatic zk_byte_t zk_xtime(zk_byte_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? `ZK_AES_POLY : 8'h00);
  endfunction

  // Full GF(2^8) product by shift and add
  function automatic zk_byte_t zk_gf_mul(zk_byte_t a, zk_byte_t b);
    zk_byte_t acc;
    zk_byte_t sh;
    acc = '0;
    sh  = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        acc = acc ^ sh;
      end
      sh = zk_xtime(sh);
    end
    return acc;
  endfunction

endpackage

`default_nettype wire

// ==== hw/aes/zk_aes_sbox.sv ====
/*
 * AES S-box, forward or inverse
 * GF(2^8) inversion with the affine map after (forward) or before (inverse)
 */
`timescale 1ns/100ps
`default_nettype none

module zk_aes_sbox
  import zk_data_pkg::*;
(
  input  logic     inverse_i,
  input  zk_byte_t byte_i,
  output zk_byte_t byte_o
);

  function automatic zk_byte_t rotl8(zk_byte_t b, int unsigned n);
    return (b << n) | (b >> (8 - n));
  endfunction

  // Forward affine transform with constant 0x63
  function automatic zk_byte_t affine_fwd(zk_byte_t b);
    return b ^ rotl8(b, 1) ^ rotl8(b, 2) ^ rotl8(b, 3) ^ rotl8(b, 4) ^ 8'h63;
  endfunction

  // Inverse affine transform with constant 0x05
  function automatic zk_byte_t affine_inv(zk_byte_t b);
    return rotl8(b, 1) ^ rotl8(b, 3) ^ rotl8(b, 6) ^ 8'h05;
  endfunction

  function automatic zk_byte_t gf_sq(zk_byte_t b);
    return zk_gf_mul(b, b);
  endfunction

  // x^254 is the inverse for nonzero x, zero stays zero
  function automatic zk_byte_t gf_inv(zk_byte_t x);
    zk_byte_t x3;
    zk_byte_t x7;
    zk_byte_t x15;
    zk_byte_t x31;
    zk_byte_t x63;
    zk_byte_t x127;
    x3   = zk_gf_mul(gf_sq(x), x);
    x7   = zk_gf_mul(gf_sq(x3), x);
    x15  = zk_gf_mul(gf_sq(x7), x);
    x31  = zk_gf_mul(gf_sq(x15), x);
    x63  = zk_gf_mul(gf_sq(x31), x);
    x127 = zk_gf_mul(gf_sq(x63), x);
    return gf_sq(x127);
  endfunction

  zk_byte_t inv_in;
  zk_byte_t inv_out;

  always_comb begin
    if (inverse_i) begin
      inv_in = affine_inv(byte_i);
    end else begin
      inv_in = byte_i;
    end
  end

  assign inv_out = gf_inv(inv_in);

  always_comb begin
    if (inverse_i) begin
      byte_o = inv_out;
    end else begin
      byte_o = affine_fwd(inv_out);
    end
  end

endmodule

`default_nettype wire

// ==== hw/aes/zk_aes32_round.sv ====
/*
 * AES32 byte operation
 * Selected byte through the S-box, optional (Inv)MixColumns, rotate, XOR
 */
`timescale 1ns/100ps
`default_nettype none

`include "zk_params.svh"

module zk_aes32_round
  import zk_data_pkg::*;
(
  input  logic [$clog2(`ZK_BYTES)-1:0] byte_sel_i,
  input  logic                         decrypt_i,
  input  logic                         mix_i,
  input  zk_word_t                     operand_a_i,
  input  zk_word_t                     operand_b_i,
  output zk_word_t                     result_o
);

  zk_byte_t                 sel_byte;
  zk_byte_t                 sbox_byte;
  zk_byte_t                 x2;
  zk_byte_t                 x4;
  zk_byte_t                 x8;
  zk_byte_t [`ZK_BYTES-1:0] column;
  zk_word_t                 sbox_word;
  zk_word_t                 rotated;
  logic [4:0]               rot_amt;

  assign rot_amt  = {byte_sel_i, 3'b000};
  assign sel_byte = operand_b_i[rot_amt +: 8];

  zk_aes_sbox i_zk_aes_sbox (
    .inverse_i (decrypt_i),
    .byte_i    (sel_byte),
    .byte_o    (sbox_byte)
  );

  assign x2 = zk_xtime(sbox_byte);
  assign x4 = zk_xtime(x2);
  assign x8 = zk_xtime(x4);

  // One column, byte 3 down to byte 0
  always_comb begin
    if (decrypt_i) begin
      column[3] = x8 ^ x2 ^ sbox_byte;
      column[2] = x8 ^ x4 ^ sbox_byte;
      column[1] = x8 ^ sbox_byte;
      column[0] = x8 ^ x4 ^ x2;
    end else begin
      column[3] = x2 ^ sbox_byte;
      column[2] = sbox_byte;
      column[1] = sbox_byte;
      column[0] = x2;
    end
  end

  assign sbox_word = mix_i ? column : {{(`ZK_XLEN-8){1'b0}}, sbox_byte};

  // Shift by the full width yields zero, so byte 0 needs no special case
  assign rotated  = (sbox_word << rot_amt) | (sbox_word >> (`ZK_XLEN - rot_amt));
  assign result_o = rotated ^ operand_a_i;

endmodule

`default_nettype wire

// ==== hw/zk_sha_sigma.sv ====
/*
 * SHA-256 sigma/sum and SHA-512 RV32 half-word functions
 */
`timescale 1ns/100ps
`default_nettype none

`include "zk_params.svh"

module zk_sha_sigma
  import zk_op_pkg::*;
  import zk_data_pkg::*;
(
  input  zk_op_e   op_i,
  input  zk_word_t operand_a_i,
  input  zk_word_t operand_b_i,
  output zk_word_t result_o
);

  function automatic zk_word_t ror(zk_word_t w, int unsigned n);
    return (w >> n) | (w << (`ZK_XLEN - n));
  endfunction

  zk_word_t a;
  zk_word_t b;

  assign a = operand_a_i;
  assign b = operand_b_i;

  always_comb begin
    case (op_i)
      ZK_SHA256SIG0: result_o = ror(a, 7) ^ ror(a, 18) ^ (a >> 3);
      ZK_SHA256SIG1: result_o = ror(a, 17) ^ ror(a, 19) ^ (a >> 10);
      ZK_SHA256SUM0: result_o = ror(a, 2) ^ ror(a, 13) ^ ror(a, 22);
      ZK_SHA256SUM1: result_o = ror(a, 6) ^ ror(a, 11) ^ ror(a, 25);

      // Each 64-bit function split over the two halves in a and b
      ZK_SHA512SUM0R: begin
        result_o = (a << 25) ^ (a << 30) ^ (a >> 28) ^
                   (b >> 7) ^ (b >> 2) ^ (b << 4);
      end
      ZK_SHA512SUM1R: begin
        result_o = (a << 23) ^ (a >> 14) ^ (a >> 18) ^
                   (b >> 9) ^ (b << 18) ^ (b << 14);
      end
      ZK_SHA512SIG0L: begin
        result_o = (a >> 1) ^ (a >> 7) ^ (a >> 8) ^
                   (b << 31) ^ (b << 25) ^ (b << 24);
      end
      ZK_SHA512SIG0H: begin
        // High half drops the b << 25 term of the plain shift
        result_o = (a >> 1) ^ (a >> 7) ^ (a >> 8) ^
                   (b << 31) ^ (b << 24);
      end
      ZK_SHA512SIG1L: begin
        result_o = (a << 3) ^ (a >> 6) ^ (a >> 19) ^
                   (b >> 29) ^ (b << 26) ^ (b << 13);
      end
      ZK_SHA512SIG1H: begin
        result_o = (a << 3) ^ (a >> 6) ^ (a >> 19) ^
                   (b >> 29) ^ (b << 13);
      end
      default: result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/zk_unit.sv ====
/*
 * Zkn scalar execute unit
 * Decodes the operation and merges AES32 and SHA results
 */
`timescale 1ns/100ps
`default_nettype none

`include "zk_params.svh"

module zk_unit
  import zk_op_pkg::*;
  import zk_data_pkg::*;
(
  input  zk_op_e   op_i,
  input  zk_word_t operand_a_i,
  input  zk_word_t operand_b_i,
  output zk_word_t result_o,
  output logic     hit_o
);

  logic                         aes_sel;
  logic                         sha_sel;
  logic                         op_legal;
  logic [$clog2(`ZK_BYTES)-1:0] aes_byte;
  logic                         aes_dec;
  logic                         aes_mix;
  zk_word_t                     aes_result;
  zk_word_t                     sha_result;

  assign aes_sel = zk_op_is_aes32(op_i);
  assign sha_sel = zk_op_is_sha(op_i);

  // AES32 code layout is {1, decrypt, mix, byte index}
  assign aes_byte = op_i[1:0];
  assign aes_mix  = op_i[2];
  assign aes_dec  = op_i[3];

  zk_aes32_round i_zk_aes32_round (
    .byte_sel_i  (aes_byte),
    .decrypt_i   (aes_dec),
    .mix_i       (aes_mix),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .result_o    (aes_result)
  );

  zk_sha_sigma i_zk_sha_sigma (
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .result_o    (sha_result)
  );

  always_comb begin
    if (aes_sel) begin
      result_o = aes_result;
    end else if (sha_sel) begin
      result_o = sha_result;
    end else begin
      result_o = '0;
    end
  end

  assign hit_o = (op_i != ZK_NONE);

  // Codes 11 to 15 are holes in the encoding
  assign op_legal = aes_sel | sha_sel | (op_i == ZK_NONE);

  always_comb begin
    assert (op_legal) else $error("zk_unit: undefined operation code %0d", op_i);
  end

endmodule

`default_nettype wire

// ==== hw/zk_exec_stage.sv ====
/*
 * Zkn execute stage
 * One registered stage around the scalar crypto unit
 */
`timescale 1ns/100ps
`default_nettype none

module zk_exec_stage
  import zk_data_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,
  input  zk_req_t req_i,
  output zk_rsp_t rsp_o
);

  zk_word_t unit_result;
  logic     unit_hit;
  zk_rsp_t  rsp_q;

  zk_unit i_zk_unit (
    .op_i        (req_i.op),
    .operand_a_i (req_i.operand_a),
    .operand_b_i (req_i.operand_b),
    .result_o    (unit_result),
    .hit_o       (unit_hit)
  );

  // Result loads every cycle, only the strobes follow valid
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_q <= '0;
    end else begin
      rsp_q.valid  <= req_i.valid;
      rsp_q.hit    <= req_i.valid & unit_hit;
      rsp_q.result <= unit_result;
    end
  end

  assign rsp_o = rsp_q;

  a_reset_clears_valid : assert property (
    @(posedge clk_i) reset_i |=> !rsp_o.valid
  );

  a_hit_needs_valid : assert property (
    @(posedge clk_i) disable iff (reset_i) rsp_o.hit |-> rsp_o.valid
  );

  // Response strobe is the request strobe one cycle late
  a_valid_follows_req : assert property (
    @(posedge clk_i) disable iff (reset_i) 1'b1 |=> (rsp_o.valid == $past(req_i.valid))
  );

endmodule

`default_nettype wire

// ==== sim/zk_vectors.svh ====
/*
 * Zkn execute stage test vectors
 * Each row holds name, valid, op, operand a, operand b, source of expected and expected result
 */
`ifndef ZK_VECTORS_SVH
`define ZK_VECTORS_SVH

  task automatic load_vectors();
    // SHA-256 on fixed operands, then random ones
    add_row("sha256_sig0", 1'b1, ZK_SHA256SIG0, 32'h6162_6380, 32'h0, BY_MODEL, '0);
    add_row("sha256_sig1", 1'b1, ZK_SHA256SIG1, 32'h0000_0018, 32'h0, BY_MODEL, '0);
    add_row("sha256_sum0", 1'b1, ZK_SHA256SUM0, 32'h6a09_e667, 32'h0, BY_MODEL, '0);
    add_row("sha256_sum1", 1'b1, ZK_SHA256SUM1, 32'h510e_527f, 32'h0, BY_MODEL, '0);
    add_row("sig0_rand", 1'b1, ZK_SHA256SIG0, $urandom, $urandom, BY_MODEL, '0);
    add_row("sig1_rand", 1'b1, ZK_SHA256SIG1, $urandom, $urandom, BY_MODEL, '0);
    add_row("sum0_rand", 1'b1, ZK_SHA256SUM0, $urandom, $urandom, BY_MODEL, '0);
    add_row("sum1_rand", 1'b1, ZK_SHA256SUM1, $urandom, $urandom, BY_MODEL, '0);
    // SHA-512 L and R forms take the low word in a and the high word in b
    // H forms take the high word in a
    add_row("sum0r", 1'b1, ZK_SHA512SUM0R, 32'hf3bc_c908, 32'h6a09_e667, BY_MODEL, '0);
    add_row("sum1r", 1'b1, ZK_SHA512SUM1R, 32'hade6_82d1, 32'h510e_527f, BY_MODEL, '0);
    add_row("sig0l", 1'b1, ZK_SHA512SIG0L, 32'h89ab_cdef, 32'h0123_4567, BY_MODEL, '0);
    add_row("sig0h", 1'b1, ZK_SHA512SIG0H, 32'h0123_4567, 32'h89ab_cdef, BY_MODEL, '0);
    add_row("sig1l", 1'b1, ZK_SHA512SIG1L, 32'hfedc_ba98, 32'h7654_3210, BY_MODEL, '0);
    add_row("sig1h", 1'b1, ZK_SHA512SIG1H, 32'h7654_3210, 32'hfedc_ba98, BY_MODEL, '0);
    add_row("sig0l_rand", 1'b1, ZK_SHA512SIG0L, $urandom, $urandom, BY_MODEL, '0);
    add_row("sig1h_rand", 1'b1, ZK_SHA512SIG1H, $urandom, $urandom, BY_MODEL, '0);
    // Known S-box pairs 00/63, 01/7c, 53/ed placed at each byte of b
    add_row("esb0", 1'b1, ZK_AES32ESB0, 32'h0000_0000, 32'haabb_cc00, GIVEN, 32'h0000_0063);
    add_row("esb1", 1'b1, ZK_AES32ESB1, 32'h0000_0000, 32'h1122_0133, GIVEN, 32'h0000_7c00);
    add_row("esb2", 1'b1, ZK_AES32ESB2, 32'hffff_ffff, 32'h4453_6677, GIVEN, 32'hff12_ffff);
    add_row("esb3", 1'b1, ZK_AES32ESB3, 32'h1234_5678, 32'h00ff_ffff, GIVEN, 32'h7134_5678);
    add_row("dsb0", 1'b1, ZK_AES32DSB0, 32'h0000_0000, 32'h1234_5663, GIVEN, 32'h0000_0000);
    add_row("dsb1", 1'b1, ZK_AES32DSB1, 32'h0000_0000, 32'hffff_7cff, GIVEN, 32'h0000_0100);
    add_row("dsb2", 1'b1, ZK_AES32DSB2, 32'h0101_0101, 32'h00ed_0000, GIVEN, 32'h0152_0101);
    add_row("dsb3", 1'b1, ZK_AES32DSB3, 32'hdead_beef, 32'h6311_2233, GIVEN, 32'hdead_beef);
    // MixColumns forms
    add_row("esmb0", 1'b1, ZK_AES32ESMB0, 32'h0000_0000, 32'h0000_0001, GIVEN, 32'h847c_7cf8);
    add_row("esmb1", 1'b1, ZK_AES32ESMB1, $urandom, 32'h0000_5300, BY_MODEL, '0);
    add_row("esmb2", 1'b1, ZK_AES32ESMB2, 32'hffff_0000, 32'h0000_0000, BY_MODEL, '0);
    add_row("esmb3", 1'b1, ZK_AES32ESMB3, 32'h0f0f_0f0f, 32'h0100_0000, BY_MODEL, '0);
    add_row("dsmb0", 1'b1, ZK_AES32DSMB0, 32'h0000_0000, 32'h0000_007c, BY_MODEL, '0);
    add_row("dsmb1", 1'b1, ZK_AES32DSMB1, $urandom, 32'h0000_ed00, BY_MODEL, '0);
    add_row("dsmb2", 1'b1, ZK_AES32DSMB2, 32'h1234_5678, 32'h0063_0000, BY_MODEL, '0);
    add_row("dsmb3", 1'b1, ZK_AES32DSMB3, 32'h8000_0001, 32'hed00_0000, BY_MODEL, '0);
    // Non-Zk op, a missing strobe and a request right after the gap
    add_row("none", 1'b1, ZK_NONE, 32'hdead_beef, 32'h1234_5678, BY_MODEL, '0);
    add_row("no_valid", 1'b0, ZK_SHA256SUM0, 32'h1111_1111, 32'h2222_2222, BY_MODEL, '0);
    add_row("after_gap", 1'b1, ZK_AES32ESB0, 32'h0000_0000, 32'h0, GIVEN, 32'h0000_0063);
  endtask

`endif

// ==== sim/tb_zk_exec.sv ====
/*
 * Testbench for the Zkn execute stage
 * Table rows issued back to back with each response checked one cycle later
 */
`timescale 1ns/100ps
`default_nettype none

`include "zk_params.svh"

module tb_zk_exec
  import zk_op_pkg::*;
  import zk_data_pkg::*;
();

  localparam logic BY_MODEL = 1'b1;
  localparam logic GIVEN    = 1'b0;

  typedef struct packed {
    logic     valid;
    zk_op_e   op;
    zk_word_t a;
    zk_word_t b;
    logic     use_model;
    zk_word_t expected;
  } row_t;

  logic    clk;
  logic    reset;
  zk_req_t req;
  zk_rsp_t rsp;

  row_t    rows[$];
  string   row_names[$];
  zk_rsp_t pending[$];
  string   pending_names[$];
  int      errors = 0;
  bit      table_ready = 1'b0;

  zk_exec_stage i_zk_exec_stage (
    .clk_i   (clk),
    .reset_i (reset),
    .req_i   (req),
    .rsp_o   (rsp)
  );

  always #10 clk = ~clk;

  task automatic stop_on_failure();
    errors++;
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic add_row(string name, logic valid, zk_op_e op, zk_word_t a, zk_word_t b,
                         logic use_model, zk_word_t expected);
    rows.push_back(row_t'{valid, op, a, b, use_model, expected});
    row_names.push_back(name);
  endtask

  `include "zk_vectors.svh"

  function automatic zk_byte_t times_x(zk_byte_t s);
    logic [8:0] d;
    d = {s, 1'b0};
    if (d[8]) begin
      d[7:0] = d[7:0] ^ `ZK_AES_POLY;
    end
    return d[7:0];
  endfunction

  // Multiplies s by a coefficient up to 15 with one doubling per coefficient bit
  function automatic zk_byte_t coef_mul(zk_byte_t s, logic [3:0] coef);
    zk_byte_t acc;
    zk_byte_t p;
    acc = 8'h00;
    p   = s;
    for (int i = 0; i < 4; i++) begin
      if (coef[i]) begin
        acc = acc ^ p;
      end
      p = times_x(p);
    end
    return acc;
  endfunction

  function automatic zk_byte_t sbox_known(logic inverse, zk_byte_t x);
    case ({inverse, x})
      9'h000: return 8'h63;
      9'h001: return 8'h7c;
      9'h053: return 8'hed;
      9'h163: return 8'h00;
      9'h17c: return 8'h01;
      9'h1ed: return 8'h53;
      default: return 8'hxx;
    endcase
  endfunction

  function automatic zk_word_t aes_model(logic dec, logic mix, int idx,
                                         zk_word_t a, zk_word_t b);
    zk_byte_t s;
    zk_word_t w;
    s = sbox_known(dec, b[8*idx +: 8]);
    if (!mix) begin
      w = {24'h0, s};
    end else if (dec) begin
      w = {coef_mul(s, 11), coef_mul(s, 13), coef_mul(s, 9), coef_mul(s, 14)};
    end else begin
      w = {coef_mul(s, 3), s, s, coef_mul(s, 2)};
    end
    for (int i = 0; i < idx; i++) begin
      w = {w[23:0], w[31:24]};
    end
    return w ^ a;
  endfunction

  function automatic zk_word_t ror32(zk_word_t w, int n);
    return (w >> n) | (w << (32 - n));
  endfunction

  function automatic logic [63:0] ror64(logic [63:0] x, int n);
    return (x >> n) | (x << (64 - n));
  endfunction

  // Full 64-bit SHA-512 function and then the half that the instruction returns
  function automatic zk_word_t sha512_model(zk_op_e op, zk_word_t a, zk_word_t b);
    logic [63:0] x;
    logic [63:0] y;
    logic        high;
    high = (op == ZK_SHA512SIG0H) || (op == ZK_SHA512SIG1H);
    x    = high ? {a, b} : {b, a};
    case (op)
      ZK_SHA512SUM0R: y = ror64(x, 28) ^ ror64(x, 34) ^ ror64(x, 39);
      ZK_SHA512SUM1R: y = ror64(x, 14) ^ ror64(x, 18) ^ ror64(x, 41);
      ZK_SHA512SIG0L, ZK_SHA512SIG0H: y = ror64(x, 1) ^ ror64(x, 8) ^ (x >> 7);
      default: y = ror64(x, 19) ^ ror64(x, 61) ^ (x >> 6);
    endcase
    return high ? y[63:32] : y[31:0];
  endfunction

  function automatic zk_word_t model_result(zk_op_e op, zk_word_t a, zk_word_t b);
    case (op)
      ZK_NONE:       return '0;
      ZK_SHA256SIG0: return ror32(a, 7) ^ ror32(a, 18) ^ (a >> 3);
      ZK_SHA256SIG1: return ror32(a, 17) ^ ror32(a, 19) ^ (a >> 10);
      ZK_SHA256SUM0: return ror32(a, 2) ^ ror32(a, 13) ^ ror32(a, 22);
      ZK_SHA256SUM1: return ror32(a, 6) ^ ror32(a, 11) ^ ror32(a, 25);
      ZK_AES32ESB0, ZK_AES32ESB1, ZK_AES32ESB2, ZK_AES32ESB3:
        return aes_model(1'b0, 1'b0, int'(op) - int'(ZK_AES32ESB0), a, b);
      ZK_AES32ESMB0, ZK_AES32ESMB1, ZK_AES32ESMB2, ZK_AES32ESMB3:
        return aes_model(1'b0, 1'b1, int'(op) - int'(ZK_AES32ESMB0), a, b);
      ZK_AES32DSB0, ZK_AES32DSB1, ZK_AES32DSB2, ZK_AES32DSB3:
        return aes_model(1'b1, 1'b0, int'(op) - int'(ZK_AES32DSB0), a, b);
      ZK_AES32DSMB0, ZK_AES32DSMB1, ZK_AES32DSMB2, ZK_AES32DSMB3:
        return aes_model(1'b1, 1'b1, int'(op) - int'(ZK_AES32DSMB0), a, b);
      default: return sha512_model(op, a, b);
    endcase
  endfunction

  // Without a request strobe only the strobes are defined
  task automatic check_response(string name, zk_rsp_t exp);
    if (exp.valid) begin
      assert (rsp === exp) else begin
        $display("Fail %s: expected valid %b hit %b result %h, actual valid %b hit %b result %h",
                 name, exp.valid, exp.hit, exp.result, rsp.valid, rsp.hit, rsp.result);
        stop_on_failure();
      end
    end else begin
      assert (rsp.valid === 1'b0 && rsp.hit === 1'b0) else begin
        $display("Fail %s: expected valid 0 hit 0, actual valid %b hit %b",
                 name, rsp.valid, rsp.hit);
        stop_on_failure();
      end
    end
  endtask

  task automatic compare_pending();
    if (pending.size() > 0) begin
      check_response(pending_names.pop_front(), pending.pop_front());
    end
  endtask

  task automatic drive_row(int i);
    zk_rsp_t exp;
    req        = zk_req_t'{rows[i].valid, rows[i].op, rows[i].a, rows[i].b};
    exp.valid  = rows[i].valid;
    exp.hit    = rows[i].valid && (rows[i].op != ZK_NONE);
    exp.result = rows[i].use_model ? model_result(rows[i].op, rows[i].a, rows[i].b)
                                   : rows[i].expected;
    pending.push_back(exp);
    pending_names.push_back(row_names[i]);
  endtask

  initial begin
    int unsigned seed_state;
    clk        = 1'b0;
    reset      = 1'b1;
    // A live request during reset must not reach the response
    req        = zk_req_t'{1'b1, ZK_SHA256SUM0, 32'h6a09_e667, 32'h510e_527f};
    seed_state = $urandom(32'ha11f_09c4);
    load_vectors();
    table_ready = 1'b1;

    repeat (3) @(posedge clk);
    #1;
    assert (rsp === '0) else begin
      $display("Fail reset: expected %h, actual %h", zk_rsp_t'('0), rsp);
      stop_on_failure();
    end
    repeat (13) @(posedge clk);
    #1;
    reset = 1'b0;
    req   = '0;

    repeat (2) begin
      @(posedge clk);
      #1;
      check_response("idle", '0);
    end

    foreach (rows[i]) begin
      @(posedge clk);
      #1;
      compare_pending();
      drive_row(i);
    end
    @(posedge clk);
    #1;
    compare_pending();
    req = '0;

    if (errors == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      stop_on_failure();
    end
  end

  // Watchdog sized from the table, the reset and a margin
  initial begin
    wait (table_ready);
    #((rows.size() + 16 + 50) * 20);
    $display("Timeout: the run did not finish within %0d clock cycles", rows.size() + 66);
    stop_on_failure();
  end

endmodule

`default_nettype wire

// ==== zk_scalar.f ====
+incdir+common
+incdir+sim
common/zk_op_pkg.sv
common/zk_data_pkg.sv
hw/aes/zk_aes_sbox.sv
hw/aes/zk_aes32_round.sv
hw/zk_sha_sigma.sv
hw/zk_unit.sv
hw/zk_exec_stage.sv
sim/tb_zk_exec.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the Zkn execute stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_zk_exec -Mdir obj_dir -o tb_zk_exec \
  -f zk_scalar.f \
  && ./obj_dir/tb_zk_exec > sim.log 2>&1 \
  || echo "Build or simulation ended with an error"

cat sim.log 2>/dev/null

grep -q "^PASS: all tests$" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
